//--- Makefile
# Verilator build and run of the video core testbench
TOP = ikari_video_core_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f ikari_video_core.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- ikari_video_core.f
source/video_timing_pkg.sv
source/video_regs_pkg.sv
source/video_timing.sv
source/video_registers.sv
source/scroll_coord.sv
source/layer_mixer.sv
source/palette_lookup.sv
source/ikari_video_core.sv
verification/ikari_video_core_asserts.sv
verification/ikari_video_core_tb.sv

//--- source/ikari_video_core.sv
//**************************************************************************
// Ikari video core
// Timing, coordinate, mixer and palette stages of the video back end
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module ikari_video_core
    import video_timing_pkg::*;
    import video_regs_pkg::*;
(
    input  logic       i_clk,       // 53.6 MHz
    input  logic       i_rst_n,
    input  logic       i_reg_we,
    input  logic [1:0] i_reg_addr,
    input  cpu_data_u  i_reg_data,
    input  logic       i_pal_we,
    input  pal_index_t i_pal_addr,
    input  rgb_t       i_pal_data,
    input  layer_px_t  i_layer_px,
    output rgb_t       o_rgb,
    output logic       o_hsync,
    output logic       o_vsync,
    output logic       o_hblank,
    output logic       o_vblank,
    output logic       o_de,
    output logic       o_pix_en,
    output coord_t     o_scr_x,
    output coord_t     o_scr_y,
    output coord_t     o_back_x,
    output coord_t     o_back_y
);

    vid_timing_t raw_timing;
    vid_timing_t pipe_timing;   // One pixel behind the counters
    video_regs_t regs;
    pal_index_t  mix_index;
    logic        mix_de;

    video_timing u_timing (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .o_pix_en (o_pix_en),
        .o_timing (raw_timing)
    );

    video_registers u_regs (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_reg_we   (i_reg_we),
        .i_reg_addr (i_reg_addr),
        .i_reg_data (i_reg_data),
        .o_regs     (regs)
    );

    scroll_coord u_coord (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_pix_en (o_pix_en),
        .i_timing (raw_timing),
        .i_regs   (regs),
        .o_timing (pipe_timing),
        .o_back_x (o_back_x),
        .o_back_y (o_back_y)
    );

    layer_mixer u_mixer (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_pix_en    (o_pix_en),
        .i_de        (pipe_timing.de),
        .i_px        (i_layer_px),
        .i_side_bank (regs.side_bank),
        .o_index     (mix_index),
        .o_de        (mix_de)
    );

    palette_lookup u_palette (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_pix_en   (o_pix_en),
        .i_de       (mix_de),
        .i_index    (mix_index),
        .i_pal_we   (i_pal_we),
        .i_pal_addr (i_pal_addr),
        .i_pal_data (i_pal_data),
        .o_rgb      (o_rgb)
    );

    assign o_hsync  = pipe_timing.hsync;
    assign o_vsync  = pipe_timing.vsync;
    assign o_hblank = pipe_timing.hblank;
    assign o_vblank = pipe_timing.vblank;
    assign o_de     = pipe_timing.de;
    assign o_scr_x  = pipe_timing.h;
    assign o_scr_y  = pipe_timing.v;

endmodule

`default_nettype wire

//--- source/layer_mixer.sv
//**************************************************************************
// Layer priority mixer
// Picks side, front or back pixel and forms the palette index
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module layer_mixer
    import video_regs_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_pix_en,
    input  logic       i_de,
    input  layer_px_t  i_px,
    input  logic [2:0] i_side_bank,
    output pal_index_t o_index,
    output logic       o_de
);

    pal_index_t win_index;
    logic       side_hit;
    logic       front_hit;
    logic       back_hit;

    assign side_hit  = i_px.ena[ENA_SIDE] && (i_px.side != TRANSPARENT_NIB);
    assign front_hit = i_px.ena[ENA_FRONT] && (i_px.front[3:0] != TRANSPARENT_NIB);
    assign back_hit  = i_px.ena[ENA_BACK];  // No see-through colour on back

    always_comb begin
        win_index = '0;
        if (side_hit) begin
            win_index.layer = LAYER_SIDE;
            win_index.px    = {1'b0, i_side_bank, i_px.side};
        end else if (front_hit) begin
            win_index.layer = LAYER_FRONT;
            win_index.px    = i_px.front;
        end else if (back_hit) begin
            win_index.layer = LAYER_BACK;
            win_index.px    = i_px.back;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_index <= '0;
            o_de    <= 1'b0;
        end else if (i_pix_en) begin
            o_index <= win_index;
            o_de    <= i_de;  // Keeps de aligned with the index
        end
    end

endmodule

`default_nettype wire

//--- source/palette_lookup.sv
//**************************************************************************
// Palette lookup
// CPU-written RGB444 colour RAM with a registered, blanked pixel read
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module palette_lookup
    import video_regs_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_pix_en,
    input  logic       i_de,
    input  pal_index_t i_index,
    input  logic       i_pal_we,
    input  pal_index_t i_pal_addr,
    input  rgb_t       i_pal_data,
    output rgb_t       o_rgb
);

    rgb_t pal_mem [PAL_DEPTH];

    // CPU port
    always_ff @(posedge i_clk) begin
        if (i_pal_we) begin
            pal_mem[i_pal_addr] <= i_pal_data;
        end
    end

    // Video port, black outside the display window
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_rgb <= '0;
        end else if (i_pix_en) begin
            if (i_de) begin
                o_rgb <= pal_mem[i_index];
            end else begin
                o_rgb <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/scroll_coord.sv
//**************************************************************************
// Back layer coordinate stage
// Registers the timing and applies flip and scroll to the screen position
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module scroll_coord
    import video_timing_pkg::*;
    import video_regs_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_pix_en,
    input  vid_timing_t i_timing,
    input  video_regs_t i_regs,
    output vid_timing_t o_timing,
    output coord_t      o_back_x,
    output coord_t      o_back_y
);

    coord_t flip_x;
    coord_t flip_y;

    // Flipped screen counts down from 511
    assign flip_x = i_regs.inv ? ~i_timing.h : i_timing.h;
    assign flip_y = i_regs.inv ? ~i_timing.v : i_timing.v;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_timing <= '0;
            o_back_x <= '0;
            o_back_y <= '0;
        end else if (i_pix_en) begin
            o_timing <= i_timing;
            o_back_x <= flip_x + i_regs.scroll_x;  // Wraps at 512
            o_back_y <= flip_y + i_regs.scroll_y;
        end
    end

endmodule

`default_nettype wire

//--- source/video_registers.sv
//**************************************************************************
// Video registers
// Decodes CPU writes into back scroll, flip and side bank state
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module video_registers
    import video_regs_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_reg_we,
    input  logic [1:0]  i_reg_addr,
    input  cpu_data_u   i_reg_data,
    output video_regs_t o_regs
);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_regs <= '0;
        end else if (i_reg_we) begin
            case (i_reg_addr)
                REG_B1SX: begin
                    o_regs.scroll_x[7:0] <= i_reg_data.scroll_lsb;
                end
                REG_B1SY: begin
                    o_regs.scroll_y[7:0] <= i_reg_data.scroll_lsb;
                end
                // Ninth scroll bits share a byte with the flip bit
                REG_BSET: begin
                    o_regs.inv         <= i_reg_data.attr.inv;
                    o_regs.scroll_x[8] <= i_reg_data.attr.b1x8;
                    o_regs.scroll_y[8] <= i_reg_data.attr.b1y8;
                end
                REG_SSET: begin
                    o_regs.side_bank <= i_reg_data[2:0];  // SD6~4 on the board
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/video_regs_pkg.sv
//**************************************************************************
// Video register package
// CPU register map, layer pixel bundle, palette index and colour types
//**************************************************************************
`default_nettype none

package video_regs_pkg;

    localparam logic [1:0] REG_B1SX = 2'd0;  // Back scroll X low byte
    localparam logic [1:0] REG_B1SY = 2'd1;  // Back scroll Y low byte
    localparam logic [1:0] REG_BSET = 2'd2;
    localparam logic [1:0] REG_SSET = 2'd3;  // Side colour bank

    // Enable mask bit positions, as on the board's layer debug mask
    localparam int ENA_SIDE  = 0;
    localparam int ENA_BACK  = 1;
    localparam int ENA_FRONT = 2;

    localparam logic [1:0] LAYER_BACK  = 2'd1;
    localparam logic [1:0] LAYER_FRONT = 2'd2;
    localparam logic [1:0] LAYER_SIDE  = 2'd3;

    localparam logic [3:0] TRANSPARENT_NIB = 4'h0;
    localparam int         PAL_DEPTH       = 1024;

    // BSET layout
    typedef struct packed {
        logic [4:0] rsvd;
        logic       inv;   // Flip screen
        logic       b1x8;
        logic       b1y8;
    } attr_bits_t;

    typedef union packed {
        logic [7:0] scroll_lsb;
        attr_bits_t attr;
    } cpu_data_u;

    typedef struct packed {
        video_timing_pkg::coord_t scroll_x;
        video_timing_pkg::coord_t scroll_y;
        logic                     inv;
        logic [2:0]               side_bank;
    } video_regs_t;

    typedef struct packed {
        logic [3:0] side;
        logic [7:0] front;
        logic [7:0] back;
        logic [2:0] ena;
    } layer_px_t;

    typedef struct packed {
        logic [1:0] layer;
        logic [7:0] px;
    } pal_index_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

endpackage

`default_nettype wire

//--- source/video_timing.sv
//**************************************************************************
// Video timing generator
// Pixel clock enable plus H/V counters with blank, sync and display enable
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module video_timing
    import video_timing_pkg::*;
(
    input  logic        i_clk,    // 53.6 MHz
    input  logic        i_rst_n,
    output logic        o_pix_en,
    output vid_timing_t o_timing
);

    logic [PIX_DIV_W-1:0] div_cnt;
    coord_t               h_cnt;
    coord_t               v_cnt;
    logic                 h_wrap;
    logic                 v_wrap;

    assign o_pix_en = (div_cnt == PIX_DIV_W'(PIX_DIV - 1));
    assign h_wrap   = (h_cnt == COORD_W'(H_TOTAL - 1));
    assign v_wrap   = (v_cnt == COORD_W'(V_TOTAL - 1));

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            div_cnt <= '0;
        end else if (o_pix_en) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Raster counters step once per pixel
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (o_pix_en) begin
            if (h_wrap) begin
                h_cnt <= '0;
                v_cnt <= v_wrap ? '0 : v_cnt + 1'b1;  // New line
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        o_timing.h      = h_cnt;
        o_timing.v      = v_cnt;
        o_timing.hblank = (h_cnt >= COORD_W'(H_ACTIVE));
        o_timing.vblank = (v_cnt >= COORD_W'(V_ACTIVE));
        o_timing.hsync  = (h_cnt >= COORD_W'(H_SYNC_START)) &&
                          (h_cnt <  COORD_W'(H_SYNC_END));
        o_timing.vsync  = (v_cnt >= COORD_W'(V_SYNC_START)) &&
                          (v_cnt <  COORD_W'(V_SYNC_END));
        o_timing.de     = (h_cnt < COORD_W'(H_ACTIVE)) && (v_cnt < COORD_W'(V_ACTIVE));
    end

endmodule

`default_nettype wire

//--- source/video_timing_pkg.sv
//**************************************************************************
// Video timing package
// Frame geometry of the 6.7 MHz raster and the per-pixel timing bundle
//**************************************************************************
`default_nettype none

package video_timing_pkg;

    localparam int PIX_DIV      = 8;    // 53.6 MHz down to 6.7 MHz
    localparam int PIX_DIV_W    = $clog2(PIX_DIV);

    localparam int H_TOTAL      = 384;
    localparam int H_ACTIVE     = 288;
    localparam int H_SYNC_START = 312;
    localparam int H_SYNC_END   = 344;  // First pixel after sync

    localparam int V_TOTAL      = 264;
    localparam int V_ACTIVE     = 216;
    localparam int V_SYNC_START = 232;
    localparam int V_SYNC_END   = 240;

    localparam int COORD_W      = 9;

    typedef logic [COORD_W-1:0] coord_t;

    // One pixel's counters and strobes
    typedef struct packed {
        coord_t h;
        coord_t v;
        logic   hblank;
        logic   vblank;
        logic   hsync;
        logic   vsync;
        logic   de;
    } vid_timing_t;

endpackage

`default_nettype wire

//--- verification/ikari_video_core_asserts.sv
//**************************************************************************
// Video core assertions
// Sync, blank and display enable relations on the core outputs
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module ikari_video_core_asserts
    import video_regs_pkg::*;
(
    input logic i_clk,
    input logic i_rst_n,
    input logic i_pix_en,
    input logic i_hsync,
    input logic i_vsync,
    input logic i_hblank,
    input logic i_vblank,
    input logic i_de,
    input rgb_t i_rgb
);

    logic [1:0] de_hist;  // de one and two pixels back

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            de_hist <= '0;
        end else if (i_pix_en) begin
            de_hist <= {de_hist[0], i_de};
        end
    end

    hsync_in_hblank: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_hsync |-> i_hblank)
        else $error("hsync outside horizontal blank");

    vsync_in_vblank: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_vsync |-> i_vblank)
        else $error("vsync outside vertical blank");

    de_not_blank: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_de |-> (!i_hblank && !i_vblank))
        else $error("de high during blank");

    // Colour trails de by two pixels through mixer and palette
    rgb_black: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !de_hist[1] |-> (i_rgb == '0))
        else $error("rgb not black outside the display window");

endmodule

bind ikari_video_core ikari_video_core_asserts u_asserts (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_pix_en (o_pix_en),
    .i_hsync  (o_hsync),
    .i_vsync  (o_vsync),
    .i_hblank (o_hblank),
    .i_vblank (o_vblank),
    .i_de     (o_de),
    .i_rgb    (o_rgb)
);

`default_nettype wire

//--- verification/ikari_video_core_tb.sv
//**************************************************************************
// Ikari video core testbench
// Table-driven layer priority, palette, scroll and blanking checks
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module ikari_video_core_tb
    import video_timing_pkg::*;
    import video_regs_pkg::*;
();

    localparam int NUM_ROWS    = 8;
    localparam int PIX_TIMEOUT = 4 * PIX_DIV;            // Clocks to the next pixel
    localparam int DE_TIMEOUT  = 2 * H_TOTAL * V_TOTAL;  // Pixels to a de edge

    // One stimulus row with its expected winner
    typedef struct packed {
        logic [7:0] b1sx;
        logic [7:0] b1sy;
        logic [7:0] bset;
        logic [7:0] sset;
        layer_px_t  px;
        pal_index_t exp_index;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        reg_we;
    logic [1:0]  reg_addr;
    cpu_data_u   reg_data;
    logic        pal_we;
    pal_index_t  pal_addr;
    rgb_t        pal_data;
    layer_px_t   layer_px;
    rgb_t        rgb;
    logic        hsync, vsync, hblank, vblank, de, pix_en;
    coord_t      scr_x, scr_y, back_x, back_y;

    row_t        rows [NUM_ROWS];
    rgb_t        pal_model [PAL_DEPTH];
    video_regs_t regs_model;
    logic [1:0]  de_hist;  // de of the two previous pixels
    int          exp_h;    // Model raster position of the timing outputs
    int          exp_v;

    always #5 clk = ~clk;

    ikari_video_core ikari_video_core_i (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_reg_we   (reg_we),
        .i_reg_addr (reg_addr),
        .i_reg_data (reg_data),
        .i_pal_we   (pal_we),
        .i_pal_addr (pal_addr),
        .i_pal_data (pal_data),
        .i_layer_px (layer_px),
        .o_rgb      (rgb),
        .o_hsync    (hsync),
        .o_vsync    (vsync),
        .o_hblank   (hblank),
        .o_vblank   (vblank),
        .o_de       (de),
        .o_pix_en   (pix_en),
        .o_scr_x    (scr_x),
        .o_scr_y    (scr_y),
        .o_back_x   (back_x),
        .o_back_y   (back_y)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // Flip mirrors the 9-bit screen position, then scroll wraps at 512
    function automatic coord_t back_coord(input int scr, input int scroll, input logic inv);
        int pos;
        pos = inv ? (2**COORD_W - 1) - scr : scr;
        return coord_t'((pos + scroll) % 2**COORD_W);
    endfunction

    // Moves the model raster one pixel on
    task automatic step_raster();
        if (exp_h == H_TOTAL - 1) begin
            exp_h = 0;
            exp_v = (exp_v + 1) % V_TOTAL;
        end else begin
            exp_h++;
        end
    endtask

    // Steps past the next pixel enable edge and checks that pixel
    task automatic next_pixel();
        int     n;
        coord_t exp_x;
        coord_t exp_y;
        n = 0;
        while (!pix_en) begin
            @(negedge clk);
            n++;
            if (n > PIX_TIMEOUT) fail_run("Pixel enable stopped pulsing");
        end
        @(negedge clk);
        step_raster();
        assert (scr_x == exp_h && scr_y == exp_v)
            else fail_run($sformatf("ERROR %0t: position %0d,%0d expected %0d,%0d",
                                    $time, scr_x, scr_y, exp_h, exp_v));
        assert (hblank == (exp_h >= H_ACTIVE) && vblank == (exp_v >= V_ACTIVE) &&
                hsync == (exp_h >= H_SYNC_START && exp_h < H_SYNC_END) &&
                vsync == (exp_v >= V_SYNC_START && exp_v < V_SYNC_END) &&
                de == (exp_h < H_ACTIVE && exp_v < V_ACTIVE))
            else fail_run($sformatf("ERROR %0t: blank, sync or de wrong at %0d,%0d",
                                    $time, exp_h, exp_v));
        assert (de_hist[1] || rgb == '0)
            else fail_run($sformatf("ERROR %0t: rgb %h outside display", $time, rgb));
        de_hist = {de_hist[0], de};
        exp_x = back_coord(scr_x, regs_model.scroll_x, regs_model.inv);
        exp_y = back_coord(scr_y, regs_model.scroll_y, regs_model.inv);
        assert (back_x == exp_x && back_y == exp_y)
            else fail_run($sformatf("ERROR %0t: back %h,%h expected %h,%h",
                                    $time, back_x, back_y, exp_x, exp_y));
    endtask

    task automatic wait_de(input logic level);
        int n;
        n = 0;
        while (de !== level) begin
            next_pixel();
            n++;
            if (n > DE_TIMEOUT) fail_run("Display enable never reached the wanted level");
        end
    endtask

    // Only called right after a pixel step, so no pixel edge is missed
    task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
        reg_we   = 1'b1;
        reg_addr = addr;
        reg_data = data;
        @(negedge clk);
        reg_we   = 1'b0;
    endtask

    initial begin
        row_t r;
        rgb_t exp_rgb;
        clk        = 1'b0;
        rst_n      = 1'b0;
        reg_we     = 1'b0;
        reg_addr   = '0;
        reg_data   = '0;
        pal_we     = 1'b0;
        pal_addr   = '0;
        pal_data   = '0;
        layer_px   = '0;
        regs_model = '0;
        de_hist    = 2'b11;
        exp_h      = H_TOTAL - 1;  // First pixel after reset lands on 0,0
        exp_v      = V_TOTAL - 1;
        void'($urandom(24));
        // b1sx   b1sy   bset   sset   side  front  back   ena     index
        rows[0] = {8'h12, 8'h34, 8'h00, 8'h00, 4'h5, 8'h2A, 8'h71, 3'b111, 10'h305};
        rows[1] = {8'h12, 8'h34, 8'h00, 8'h00, 4'h0, 8'h2A, 8'h71, 3'b111, 10'h22A};
        rows[2] = {8'h80, 8'h05, 8'h03, 8'h00, 4'h0, 8'h30, 8'h71, 3'b111, 10'h171};
        rows[3] = {8'h80, 8'h05, 8'h03, 8'h00, 4'h5, 8'h2A, 8'h71, 3'b110, 10'h22A};
        rows[4] = {8'hF0, 8'h0F, 8'h04, 8'h00, 4'h5, 8'h2A, 8'h71, 3'b010, 10'h171};
        rows[5] = {8'hF0, 8'h0F, 8'h04, 8'h00, 4'h5, 8'h2A, 8'h71, 3'b000, 10'h000};
        rows[6] = {8'h00, 8'h00, 8'h00, 8'h06, 4'h9, 8'h2A, 8'h71, 3'b111, 10'h369};
        rows[7] = {8'h40, 8'hC3, 8'h07, 8'h06, 4'h9, 8'h4B, 8'h00, 3'b100, 10'h24B};
        repeat (16) begin
            @(negedge clk);
            assert (!de && !hsync && !vsync)
                else fail_run($sformatf("ERROR %0t: sync or de active in reset", $time));
        end
        rst_n = 1'b1;
        for (int i = 0; i < PAL_DEPTH; i++) begin
            pal_model[i] = 12'($urandom);
            pal_we       = 1'b1;
            pal_addr     = pal_index_t'(i);
            pal_data     = pal_model[i];
            if (pix_en) step_raster();  // Pixels still advance during the fill
            @(negedge clk);
        end
        pal_we = 1'b0;
        wait_de(1'b1);
        for (int k = 0; k < NUM_ROWS; k++) begin
            r = rows[k];
            next_pixel();
            write_reg(REG_B1SX, r.b1sx);
            write_reg(REG_B1SY, r.b1sy);
            write_reg(REG_BSET, r.bset);
            write_reg(REG_SSET, r.sset);
            regs_model.scroll_x  = {r.bset[1], r.b1sx};  // Ninth bits from BSET
            regs_model.scroll_y  = {r.bset[0], r.b1sy};
            regs_model.inv       = r.bset[2];
            regs_model.side_bank = r.sset[2:0];
            layer_px = r.px;
            wait_de(1'b0);
            wait_de(1'b1);
            repeat (4) next_pixel();  // Past the mixer and palette stages
            exp_rgb = pal_model[r.exp_index];
            assert (de && rgb == exp_rgb)
                else fail_run($sformatf("ERROR %0t: row %0d rgb %h, expected %h",
                                        $time, k, rgb, exp_rgb));
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
